/* hw/rp_pkg.sv */
// shared widths, bus map, register offsets and sample types; imported by every hw module
package rp_pkg;

  ////////////////////////////////////////
  // analog data path
  ////////////////////////////////////////

  localparam int ADC_W = 14;                    // both ADC and DAC sample width

  typedef logic        [ADC_W-1:0] adc_raw_t;   // pin code, neg slope, unsigned
  typedef logic signed [ADC_W-1:0] sample_t;    // two's complement inside
  typedef logic        [ADC_W-1:0] dac_code_t;  // pin code toward DAC

  ////////////////////////////////////////
  // register bus
  ////////////////////////////////////////

  typedef logic [31:0] sys_addr_t;
  typedef logic [31:0] sys_data_t;

  localparam int N_REGIONS  = 8;                // address space split in 8
  localparam int REGION_LSB = 20;               // region number at addr[22:20]

  typedef logic [$clog2(N_REGIONS)-1:0] region_t;
  typedef logic [REGION_LSB-1:0]        reg_ofs_t;  // offset inside one region

  localparam region_t REGION_HK     = 3'd0;     // housekeeping
  localparam region_t REGION_ROUTER = 3'd1;     // signal router

  // housekeeping map
  localparam reg_ofs_t HK_ID_OFS   = 20'h00000;
  localparam reg_ofs_t HK_LOOP_OFS = 20'h00004;
  localparam reg_ofs_t HK_LED_OFS  = 20'h00030;

  localparam sys_data_t HK_ID = 32'h0001_4d52;  // board id word, read only

  // router map
  localparam reg_ofs_t RT_OUT_A_OFS = 20'h00000;
  localparam reg_ofs_t RT_OUT_B_OFS = 20'h00004;

  typedef logic [7:0] led_t;

  // source of one DAC channel
  typedef enum logic [1:0] {
    ROUTE_OFF  = 2'd0,  // constant zero
    ROUTE_IN_A = 2'd1,
    ROUTE_IN_B = 2'd2,
    ROUTE_SUM  = 2'd3   // a + b, clipped
  } route_t;

endpackage

/* hw/sys_bus_if.sv */
// one register-bus port; decoder drives it as master, each slave answers on it
interface sys_bus_if
  import rp_pkg::*;
();

  // request side, from decoder
  sys_addr_t addr;   // full address, slave decodes the low offset
  sys_data_t wdata;  // always a full word
  logic      wen;    // single cycle write strobe
  logic      ren;    // single cycle read strobe

  // response side, from slave
  sys_data_t rdata;  // valid with ack, zero otherwise
  logic      err;
  logic      ack;    // one cycle after the strobe

  modport master (
    output addr, wdata, wen, ren,
    input  rdata, err, ack
  );

  modport slave (
    input  addr, wdata, wen, ren,
    output rdata, err, ack
  );

endinterface

/* hw/sys_bus_decoder.sv */
// splits the CPU register bus into 8 regions by addr[22:20] and muxes the answers back
module sys_bus_decoder
  import rp_pkg::*;
(
  input  logic      adc_clk,
  input  logic      arst_n_i,
  // CPU side
  input  sys_addr_t sys_addr_i,
  input  sys_data_t sys_wdata_i,
  input  logic      sys_wen_i,
  input  logic      sys_ren_i,
  output sys_data_t sys_rdata_o,
  output logic      sys_err_o,
  output logic      sys_ack_o,
  // slave ports
  sys_bus_if.master hk_bus_o,
  sys_bus_if.master rt_bus_o
);

  region_t              region;
  logic [N_REGIONS-1:0] cs;      // one hot region select
  logic [1:0]           pend_q;  // [0] hk, [1] router access in flight

  assign region = sys_addr_i[REGION_LSB +: $bits(region_t)];
  assign cs     = {{(N_REGIONS-1){1'b0}}, 1'b1} << region;

  // request fan out, strobes only reach the selected slave
  assign hk_bus_o.addr  = sys_addr_i;
  assign hk_bus_o.wdata = sys_wdata_i;
  assign hk_bus_o.wen   = sys_wen_i & cs[REGION_HK];
  assign hk_bus_o.ren   = sys_ren_i & cs[REGION_HK];

  assign rt_bus_o.addr  = sys_addr_i;
  assign rt_bus_o.wdata = sys_wdata_i;
  assign rt_bus_o.wen   = sys_wen_i & cs[REGION_ROUTER];
  assign rt_bus_o.ren   = sys_ren_i & cs[REGION_ROUTER];

  // remember which slave was strobed, its answer comes next cycle
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      pend_q <= 2'b00;
    else
      pend_q <= {rt_bus_o.wen | rt_bus_o.ren, hk_bus_o.wen | hk_bus_o.ren};
  end

  ////////////////////////////////////////
  // response mux
  ////////////////////////////////////////

  always_comb
  begin
    // unused regions: instant ack, zero data
    sys_rdata_o = '0;
    sys_err_o   = 1'b0;
    sys_ack_o   = 1'b1;
    case (region)
      REGION_HK:
      begin
        sys_rdata_o = pend_q[0] ? hk_bus_o.rdata : '0;
        sys_err_o   = pend_q[0] & hk_bus_o.err;
        sys_ack_o   = pend_q[0] & hk_bus_o.ack;  // only answers to own strobe
      end
      REGION_ROUTER:
      begin
        sys_rdata_o = pend_q[1] ? rt_bus_o.rdata : '0;
        sys_err_o   = pend_q[1] & rt_bus_o.err;
        sys_ack_o   = pend_q[1] & rt_bus_o.ack;
      end
      default: ;
    endcase
  end

endmodule

/* hw/housekeeping.sv */
// housekeeping slave on bus region 0: id word, digital loop switch and LED register
module housekeeping
  import rp_pkg::*;
(
  input  logic     adc_clk,
  input  logic     arst_n_i,
  sys_bus_if.slave bus,
  output logic     digital_loop_o,  // 1 = DAC samples fed back as ADC input
  output led_t     led_o
);

  reg_ofs_t  ofs;
  sys_data_t rd_val;
  logic      loop_q;
  led_t      led_q;
  logic      ack_q;
  sys_data_t rdata_q;

  assign ofs = bus.addr[REGION_LSB-1:0];  // region bits already decoded

  ////////////////////////////////////////
  // register writes
  ////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      loop_q <= 1'b0;
      led_q  <= '0;
    end
    else if (bus.wen)
    begin
      case (ofs)
        HK_LOOP_OFS: loop_q <= bus.wdata[0];
        HK_LED_OFS:  led_q  <= led_t'(bus.wdata[7:0]);
        default: ;  // id is read only, rest ignored
      endcase
    end
  end

  // read mux
  always_comb
  begin
    case (ofs)
      HK_ID_OFS:   rd_val = HK_ID;
      HK_LOOP_OFS: rd_val = sys_data_t'(loop_q);
      HK_LED_OFS:  rd_val = sys_data_t'(led_q);
      default:     rd_val = '0;  // unknown offset reads zero
    endcase
  end

  ////////////////////////////////////////
  // bus answer, one cycle after strobe
  ////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      ack_q   <= 1'b0;
      rdata_q <= '0;
    end
    else
    begin
      ack_q   <= bus.wen | bus.ren;
      rdata_q <= bus.ren ? rd_val : '0;  // zero on write acks too
    end
  end

  assign bus.ack   = ack_q;
  assign bus.rdata = rdata_q;
  assign bus.err   = 1'b0;  // every access succeeds

  assign digital_loop_o = loop_q;
  assign led_o          = led_q;

endmodule

/* hw/analog_io.sv */
// ADC input and DAC output stage with pin registers, neg-slope code conversion and digital loop mux
module analog_io
  import rp_pkg::*;
(
  input  logic      adc_clk,
  input  logic      arst_n_i,
  // ADC pins
  input  adc_raw_t  adc_dat_a_i,
  input  adc_raw_t  adc_dat_b_i,
  input  logic      digital_loop_i,
  // from router
  input  sample_t   out_a_i,
  input  sample_t   out_b_i,
  // to router
  output sample_t   adc_a_o,
  output sample_t   adc_b_o,
  // DAC pins
  output dac_code_t dac_dat_a_o,
  output dac_code_t dac_dat_b_o
);

  adc_raw_t  adc_a_q, adc_b_q;  // input registers
  dac_code_t dac_a_q, dac_b_q;

  // sign bit kept and magnitude bits flipped in both directions
  function automatic logic [ADC_W-1:0] flip_slope(input logic [ADC_W-1:0] v);
    return {v[ADC_W-1], ~v[ADC_W-2:0]};
  endfunction

  ////////////////////////////////////////
  // ADC side
  ////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    adc_a_q <= adc_dat_a_i;
    adc_b_q <= adc_dat_b_i;
  end

  // with loop on the router output replaces the ADC sample
  assign adc_a_o = digital_loop_i ? out_a_i : sample_t'(flip_slope(adc_a_q));
  assign adc_b_o = digital_loop_i ? out_b_i : sample_t'(flip_slope(adc_b_q));

  ////////////////////////////////////////
  // DAC side
  ////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      dac_a_q <= '0;
      dac_b_q <= '0;
    end
    else
    begin
      dac_a_q <= dac_code_t'(flip_slope(out_a_i));  // signed -> neg slope
      dac_b_q <= dac_code_t'(flip_slope(out_b_i));
    end
  end

  assign dac_dat_a_o = dac_a_q;
  assign dac_dat_b_o = dac_b_q;

endmodule

/* hw/signal_router.sv */
// signal router on bus region 1: picks off, input A, input B or clipped sum for each DAC channel
module signal_router
  import rp_pkg::*;
(
  input  logic     adc_clk,
  input  logic     arst_n_i,
  sys_bus_if.slave bus,
  input  sample_t  adc_a_i,
  input  sample_t  adc_b_i,
  output sample_t  out_a_o,
  output sample_t  out_b_o
);

  reg_ofs_t  ofs;
  sys_data_t rd_val;
  route_t    route_a_q, route_b_q;
  logic      ack_q;
  sys_data_t rdata_q;
  sample_t   out_a_q, out_b_q;

  assign ofs = bus.addr[REGION_LSB-1:0];

  // source select for one channel, sum clipped to -8192..8191
  function automatic sample_t route_sel(input route_t sel, input sample_t a, input sample_t b);
    logic [ADC_W:0] sum;  // one guard bit
    sum = {a[ADC_W-1], a} + {b[ADC_W-1], b};
    case (sel)
      ROUTE_IN_A: return a;
      ROUTE_IN_B: return b;
      ROUTE_SUM:
      begin
        if (sum[ADC_W] != sum[ADC_W-1])  // overflow, guard and sign disagree
          return {sum[ADC_W], {(ADC_W-1){~sum[ADC_W]}}};
        else
          return sum[ADC_W-1:0];
      end
      default: return '0;  // off
    endcase
  endfunction

  ////////////////////////////////////////
  // route registers
  ////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      route_a_q <= ROUTE_OFF;
      route_b_q <= ROUTE_OFF;
    end
    else if (bus.wen)
    begin
      case (ofs)
        RT_OUT_A_OFS: route_a_q <= route_t'(bus.wdata[1:0]);
        RT_OUT_B_OFS: route_b_q <= route_t'(bus.wdata[1:0]);
        default: ;
      endcase
    end
  end

  always_comb
  begin
    case (ofs)
      RT_OUT_A_OFS: rd_val = sys_data_t'(route_a_q);
      RT_OUT_B_OFS: rd_val = sys_data_t'(route_b_q);
      default:      rd_val = '0;
    endcase
  end

  // bus answer
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      ack_q   <= 1'b0;
      rdata_q <= '0;
    end
    else
    begin
      ack_q   <= bus.wen | bus.ren;
      rdata_q <= bus.ren ? rd_val : '0;
    end
  end

  assign bus.ack   = ack_q;
  assign bus.rdata = rdata_q;
  assign bus.err   = 1'b0;

  ////////////////////////////////////////
  // data path, one register stage
  ////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    out_a_q <= route_sel(route_a_q, adc_a_i, adc_b_i);
    out_b_q <= route_sel(route_b_q, adc_a_i, adc_b_i);
  end

  assign out_a_o = out_a_q;
  assign out_b_o = out_b_q;

endmodule

/* hw/rp_top.sv */
// board top level: ADC/DAC pins, CPU register bus and LEDs, all on the ADC clock
module rp_top
  import rp_pkg::*;
(
  input  logic      adc_clk,
  input  logic      arst_n_i,
  // ADC
  input  adc_raw_t  adc_dat_a_i,   // channel 1
  input  adc_raw_t  adc_dat_b_i,   // channel 2
  // register bus
  input  sys_addr_t sys_addr_i,
  input  sys_data_t sys_wdata_i,
  input  logic      sys_wen_i,
  input  logic      sys_ren_i,
  output sys_data_t sys_rdata_o,
  output logic      sys_err_o,
  output logic      sys_ack_o,
  // DAC, one registered code per channel
  output dac_code_t dac_dat_a_o,
  output dac_code_t dac_dat_b_o,
  output led_t      led_o
);

  logic    digital_loop;
  sample_t adc_a, adc_b;  // converted input samples
  sample_t out_a, out_b;  // router outputs toward DAC

  sys_bus_if hk_bus ();   // region 0
  sys_bus_if rt_bus ();   // region 1

  sys_bus_decoder i_dec (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_err_o   (sys_err_o),
    .sys_ack_o   (sys_ack_o),
    .hk_bus_o    (hk_bus),
    .rt_bus_o    (rt_bus)
  );

  housekeeping i_hk (
    .adc_clk        (adc_clk),
    .arst_n_i       (arst_n_i),
    .bus            (hk_bus),
    .digital_loop_o (digital_loop),
    .led_o          (led_o)
  );

  analog_io i_aio (
    .adc_clk        (adc_clk),
    .arst_n_i       (arst_n_i),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .digital_loop_i (digital_loop),
    .out_a_i        (out_a),
    .out_b_i        (out_b),
    .adc_a_o        (adc_a),
    .adc_b_o        (adc_b),
    .dac_dat_a_o    (dac_dat_a_o),
    .dac_dat_b_o    (dac_dat_b_o)
  );

  signal_router i_rt (
    .adc_clk  (adc_clk),
    .arst_n_i (arst_n_i),
    .bus      (rt_bus),
    .adc_a_i  (adc_a),
    .adc_b_i  (adc_b),
    .out_a_o  (out_a),
    .out_b_o  (out_b)
  );

endmodule

/* dv/rp_tb_properties.sv */
// bus handshake and reset assertions on the top-level ports, bound into every rp_top instance
module rp_tb_properties
  import rp_pkg::*;
(
  input logic      adc_clk,
  input logic      arst_n_i,
  input sys_addr_t sys_addr_i,
  input logic      sys_wen_i,
  input logic      sys_ren_i,
  input sys_data_t sys_rdata_o,
  input logic      sys_err_o,
  input logic      sys_ack_o
);

  region_t region;
  logic    used_strobe;  // strobe toward hk or router

  assign region      = sys_addr_i[REGION_LSB +: $bits(region_t)];
  assign used_strobe = (sys_wen_i | sys_ren_i)
                       & (region == REGION_HK || region == REGION_ROUTER);

  ////////////////////////////////////////
  // handshake
  ////////////////////////////////////////

  ack_in_reset: assert property (@(posedge adc_clk) !arst_n_i |-> !sys_ack_o)
    else $error("ack high while reset is asserted");

  // used slaves answer one cycle late, never in the strobe cycle
  ack_not_early: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    used_strobe |-> !sys_ack_o)
    else $error("ack in the strobe cycle of a used region");

  ack_after_strobe: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    used_strobe |=> sys_ack_o)
    else $error("no ack one cycle after a strobe to a used region");

  err_low: assert property (@(posedge adc_clk) !sys_err_o)
    else $error("err went high");

  rdata_idle_zero: assert property (@(posedge adc_clk) !sys_ack_o |-> sys_rdata_o == '0)
    else $error("rdata not zero while ack is low");

endmodule

bind rp_top rp_tb_properties i_props (
  .adc_clk     (adc_clk),
  .arst_n_i    (arst_n_i),
  .sys_addr_i  (sys_addr_i),
  .sys_wen_i   (sys_wen_i),
  .sys_ren_i   (sys_ren_i),
  .sys_rdata_o (sys_rdata_o),
  .sys_err_o   (sys_err_o),
  .sys_ack_o   (sys_ack_o)
);

/* dv/rp_tb.sv */
// testbench for rp_top that runs a table of bus accesses and ADC samples against a reference model
module rp_tb
  import rp_pkg::*;
();

  typedef enum logic [1:0] {KIND_WR, KIND_RD, KIND_ADC} kind_t;

  typedef struct packed {
    kind_t     kind;
    sys_addr_t addr;   // bus entries
    sys_data_t data;   // write data
    adc_raw_t  raw_a;  // ADC entries
    adc_raw_t  raw_b;
    sys_data_t exp;    // read data, led after write, or {dac a, dac b}
  } entry_t;

  // names match the DUT ports
  logic      adc_clk, arst_n_i;
  adc_raw_t  adc_dat_a_i, adc_dat_b_i;
  sys_addr_t sys_addr_i;
  sys_data_t sys_wdata_i, sys_rdata_o;
  logic      sys_wen_i, sys_ren_i, sys_err_o, sys_ack_o;
  dac_code_t dac_dat_a_o, dac_dat_b_o;
  led_t      led_o;

  entry_t tbl[$];
  logic   tbl_ready;
  integer seed;

  // model state while the table is built
  route_t rt_a_m, rt_b_m;
  logic   loop_m;
  led_t   led_m;
  int     last_a, last_b;  // last router outputs fed back in loop mode

  rp_top UUT (.*);

  initial adc_clk = 1'b0;
  always #4 adc_clk = ~adc_clk;

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  // neg slope code runs from +8191 at code 0 down to -8192 at full code
  function automatic int code_to_val(input adc_raw_t code);
    return 8191 - int'(code);
  endfunction

  function automatic dac_code_t val_to_code(input int v);
    return dac_code_t'(8191 - v);
  endfunction

  function automatic int route_model(input route_t r, input int a, input int b);
    int s;
    s = a + b;
    if (s > 8191)
      s = 8191;   // clip high
    if (s < -8192)
      s = -8192;  // clip low
    case (r)
      ROUTE_IN_A: return a;
      ROUTE_IN_B: return b;
      ROUTE_SUM:  return s;
      default:    return 0;
    endcase
  endfunction

  // a write updates the model and a read carries its expected data in d
  task automatic add_bus(input kind_t k, input region_t rg, input reg_ofs_t ofs,
                         input sys_data_t d);
    entry_t e;
    e = '0;
    e.kind = k;
    e.addr = sys_addr_t'({rg, ofs});
    e.data = d;
    e.exp  = d;
    if (k == KIND_WR)
    begin
      if (rg == REGION_HK && ofs == HK_LOOP_OFS)
        loop_m = d[0];
      if (rg == REGION_HK && ofs == HK_LED_OFS)
        led_m = d[7:0];
      if (rg == REGION_ROUTER && ofs == RT_OUT_A_OFS)
        rt_a_m = route_t'(d[1:0]);
      if (rg == REGION_ROUTER && ofs == RT_OUT_B_OFS)
        rt_b_m = route_t'(d[1:0]);
      e.exp = sys_data_t'(led_m);
    end
    tbl.push_back(e);
  endtask

  // loop mode assumes a route setup that is its own fixed point
  task automatic add_adc(input adc_raw_t ra, input adc_raw_t rb);
    entry_t e;
    int     sa, sb;
    sa = loop_m ? last_a : code_to_val(ra);
    sb = loop_m ? last_b : code_to_val(rb);
    last_a = route_model(rt_a_m, sa, sb);
    last_b = route_model(rt_b_m, sa, sb);
    e = '0;
    e.kind  = KIND_ADC;
    e.raw_a = ra;
    e.raw_b = rb;
    e.exp   = {2'b00, val_to_code(last_a), 2'b00, val_to_code(last_b)};
    tbl.push_back(e);
  endtask

  task automatic add_rand(input int n);
    repeat (n) add_adc(adc_raw_t'($random(seed)), adc_raw_t'($random(seed)));
  endtask

  task automatic build_table();
    rt_a_m = ROUTE_OFF;
    rt_b_m = ROUTE_OFF;
    loop_m = 1'b0;
    led_m  = '0;
    last_a = 0;
    last_b = 0;
    add_bus(KIND_RD, REGION_HK, HK_ID_OFS, HK_ID);
    add_bus(KIND_WR, REGION_HK, HK_LOOP_OFS, 32'h1);
    add_bus(KIND_RD, REGION_HK, HK_LOOP_OFS, 32'h1);
    add_bus(KIND_WR, REGION_HK, HK_LOOP_OFS, 32'h0);
    add_bus(KIND_RD, REGION_HK, HK_LOOP_OFS, 32'h0);
    add_bus(KIND_WR, REGION_HK, HK_LED_OFS, 32'ha5);
    add_bus(KIND_RD, REGION_HK, HK_LED_OFS, 32'ha5);
    add_bus(KIND_WR, REGION_HK, HK_LED_OFS, 32'h3c);
    add_bus(KIND_RD, REGION_HK, HK_LED_OFS, 32'h3c);
    add_bus(KIND_RD, REGION_HK, 20'h00008, '0);      // unknown offset
    add_bus(KIND_WR, REGION_ROUTER, RT_OUT_A_OFS, sys_data_t'(ROUTE_IN_B));
    add_bus(KIND_RD, REGION_ROUTER, RT_OUT_A_OFS, sys_data_t'(ROUTE_IN_B));
    add_bus(KIND_WR, REGION_ROUTER, RT_OUT_B_OFS, sys_data_t'(ROUTE_SUM));
    add_bus(KIND_RD, REGION_ROUTER, RT_OUT_B_OFS, sys_data_t'(ROUTE_SUM));
    add_bus(KIND_RD, REGION_ROUTER, 20'h00010, '0);
    for (int rg = 2; rg < N_REGIONS; rg++)
      add_bus(KIND_RD, region_t'(rg), 20'h00000, '0);  // no slave there
    // plain routing
    add_bus(KIND_WR, REGION_ROUTER, RT_OUT_A_OFS, sys_data_t'(ROUTE_IN_A));
    add_bus(KIND_WR, REGION_ROUTER, RT_OUT_B_OFS, sys_data_t'(ROUTE_IN_B));
    add_rand(6);
    add_bus(KIND_WR, REGION_ROUTER, RT_OUT_A_OFS, sys_data_t'(ROUTE_IN_B));
    add_bus(KIND_WR, REGION_ROUTER, RT_OUT_B_OFS, sys_data_t'(ROUTE_IN_A));
    add_rand(4);
    add_bus(KIND_WR, REGION_ROUTER, RT_OUT_A_OFS, sys_data_t'(ROUTE_OFF));
    add_bus(KIND_WR, REGION_ROUTER, RT_OUT_B_OFS, sys_data_t'(ROUTE_OFF));
    add_rand(2);
    // sum with full scale codes
    add_bus(KIND_WR, REGION_ROUTER, RT_OUT_A_OFS, sys_data_t'(ROUTE_SUM));
    add_bus(KIND_WR, REGION_ROUTER, RT_OUT_B_OFS, sys_data_t'(ROUTE_SUM));
    add_adc(14'h0000, 14'h0000);  // both +8191
    add_adc(14'h3fff, 14'h3fff);  // both -8192
    add_adc(14'h0000, 14'h3fff);  // mixed signs
    add_rand(3);
    // digital loop holds a and keeps b at zero code
    add_bus(KIND_WR, REGION_ROUTER, RT_OUT_A_OFS, sys_data_t'(ROUTE_IN_A));
    add_bus(KIND_WR, REGION_ROUTER, RT_OUT_B_OFS, sys_data_t'(ROUTE_OFF));
    add_rand(1);
    add_bus(KIND_WR, REGION_HK, HK_LOOP_OFS, 32'h1);
    add_rand(3);
    add_bus(KIND_WR, REGION_HK, HK_LOOP_OFS, 32'h0);
    add_rand(2);
  endtask

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////

  task automatic check_data(input sys_data_t got, input sys_data_t exp, input string what);
    if (got !== exp)
    begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  task automatic check_dac(input dac_code_t got, input dac_code_t exp, input string what);
    if (got !== exp)
    begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  task automatic check_led(input led_t got, input led_t exp, input string what);
    if (got !== exp)
    begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  ////////////////////////////////////////
  // drivers
  ////////////////////////////////////////

  // issues one strobe and holds addr until ack
  // returns at a falling edge
  task automatic bus_access(input logic wr, input sys_addr_t addr, input sys_data_t d,
                            output sys_data_t rd);
    int waited;
    waited = 0;
    rd     = '0;
    @(posedge adc_clk);
    sys_addr_i  <= addr;
    sys_wdata_i <= d;
    sys_wen_i   <= wr;
    sys_ren_i   <= !wr;
    @(negedge adc_clk);
    while (!sys_ack_o && waited < 8)
    begin
      @(posedge adc_clk);
      sys_wen_i <= 1'b0;  // strobe lasts one cycle
      sys_ren_i <= 1'b0;
      @(negedge adc_clk);
      waited++;
    end
    if (!sys_ack_o)
    begin
      $display("bus access to address %h was never acknowledged", addr);
      $display("Test failures found");
      $fatal(1);
    end
    else
    begin
      rd = sys_rdata_o;
      @(posedge adc_clk);
      sys_wen_i <= 1'b0;
      sys_ren_i <= 1'b0;
      @(negedge adc_clk);
    end
  endtask

  task automatic apply_adc(input adc_raw_t ra, input adc_raw_t rb);
    @(posedge adc_clk);
    adc_dat_a_i <= ra;
    adc_dat_b_i <= rb;
    repeat (3) @(posedge adc_clk);  // ADC, router and DAC registers
    @(negedge adc_clk);
  endtask

  task automatic run_entry(input entry_t e);
    sys_data_t rd;
    case (e.kind)
      KIND_WR:
      begin
        bus_access(1'b1, e.addr, e.data, rd);
        check_led(led_o, e.exp[7:0], "led_o after write");
      end
      KIND_RD:
      begin
        bus_access(1'b0, e.addr, '0, rd);
        check_data(rd, e.exp, $sformatf("read of %h", e.addr));
      end
      default:
      begin
        apply_adc(e.raw_a, e.raw_b);
        check_dac(dac_dat_a_o, e.exp[29:16], "dac_dat_a_o");
        check_dac(dac_dat_b_o, e.exp[13:0], "dac_dat_b_o");
      end
    endcase
  endtask

  ////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////

  initial
  begin
    seed        = 32'hff20;
    tbl_ready   = 1'b0;
    arst_n_i    = 1'b0;
    adc_dat_a_i = '0;
    adc_dat_b_i = '0;
    sys_addr_i  = '0;  // region 0 keeps ack low when idle
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    build_table();
    tbl_ready = 1'b1;
    repeat (16) @(posedge adc_clk);
    arst_n_i <= 1'b1;
    @(negedge adc_clk);  // DAC registers still hold their reset value here
    check_led(led_o, '0, "led_o after reset");
    check_dac(dac_dat_a_o, '0, "dac_dat_a_o after reset");
    check_dac(dac_dat_b_o, '0, "dac_dat_b_o after reset");
    foreach (tbl[i])
      run_entry(tbl[i]);
    $display("All tests passed!");
    $finish;
  end

  initial
  begin
    wait (tbl_ready);
    repeat (tbl.size() * 20 + 100) @(posedge adc_clk);
    $display("watchdog expired before the stimulus table completed");
    $display("Test failures found");
    $fatal(1);
  end

endmodule

/* src.f */
hw/rp_pkg.sv
hw/sys_bus_if.sv
hw/sys_bus_decoder.sv
hw/housekeeping.sv
hw/analog_io.sv
hw/signal_router.sv
hw/rp_top.sv
dv/rp_tb_properties.sv
dv/rp_tb.sv

/* Makefile */
TOP := rp_tb

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean
